/* files.f */
design/float_pkg.sv
design/node_pkg.sv
design/float_mult.sv
design/float_adder.sv
design/node_mult_stage.sv
design/node_tree_level.sv
design/neuron_node.sv
testbench/neuron_node_asserts.sv
testbench/tb_neuron_node.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_neuron_node
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
RUN_ARGS ?= +verilator+error+limit+1000
FAIL_TEXT := Some tests failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) \
		-f $(FILELIST)

# a crashed run or the fail text in the log fails the target
sim: build
	@./$(OBJ_DIR)/$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_neuron_node.sv */
`timescale 1ns/1ps

module tb_neuron_node;

	import float_pkg::*;
	import node_pkg::*;

	typedef float_t [node_inputs-1:0] vector_t;

	localparam int period = 40;
	localparam int reset_cycles = 16;
	localparam int burst_len = 400;
	localparam int gap_len = 200;
	localparam int denorm_len = 100;
	// directed vectors, the mid-run reset and the drain stay well inside 60 cycles
	localparam int total_cycles = reset_cycles + burst_len + gap_len + denorm_len + 60;

	logic clk;
	logic reset;
	node_sample_t in;
	logic out_valid;
	float_t out;

	integer seed = 32'h5cfc_06bd;
	int cycle = 0;
	int errors = 0;
	int checks = 0;

	// expected results in arrival order
	logic [31:0] exp_val [$];
	int exp_due [$];
	string exp_name [$];

	neuron_node uut (
		.clk(clk),
		.reset(reset),
		.in(in),
		.out_valid(out_valid),
		.out(out)
	);

	initial
	begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle++;

	function automatic float_t rand_float();
		float_t v;
		logic [31:0] r;
		r = $random(seed);
		v.f.sign = r[31];
		v.f.man = r[22:0];
		r = $random(seed);
		// exponents 100 to 150
		v.f.exp = 8'(32'd100 + r % 32'd51);
		return v;
	endfunction

	function automatic vector_t rand_vector();
		vector_t v;
		for (int i = 0; i < node_inputs; i++)
			v[i] = rand_float();
		return v;
	endfunction

	function automatic float_t model_mult(input float_t x, input float_t y);
		float_t z;
		logic [47:0] m;
		int e;
		z.raw = '0;
		z.f.sign = x.f.sign ^ y.f.sign;
		m = {24'd0, 1'b1, x.f.man} * {24'd0, 1'b1, y.f.man};
		e = int'(x.f.exp) + int'(y.f.exp) - float_bias_exp;
		if (m[47])
		begin
			m = m >> 1;
			e++;
		end
		if (x.f.exp == 8'd0 || y.f.exp == 8'd0 || e < 1)
			return z;
		if (e > float_max_exp)
		begin
			z.f.exp = 8'(float_max_exp);
			z.f.man = '1;
		end
		else
		begin
			z.f.exp = 8'(e);
			z.f.man = m[45:23];
		end
		return z;
	endfunction

	function automatic float_t model_add(input float_t a, input float_t b);
		float_t p;
		float_t q;
		float_t r;
		logic [24:0] s;
		logic [24:0] t;
		int e;
		p = a;
		q = b;
		// a zero exponent means a zero value whatever the mantissa holds
		if (p.f.exp == 8'd0)
			p.f.man = '0;
		if (q.f.exp == 8'd0)
			q.f.man = '0;
		if (q.raw[30:0] > p.raw[30:0])
		begin
			r = p;
			p = q;
			q = r;
		end
		r.raw = '0;
		if (p.f.exp == 8'd0)
			return r;
		s = {2'b01, p.f.man};
		t = (q.f.exp == 8'd0) ? 25'd0 : {2'b01, q.f.man} >> (int'(p.f.exp) - int'(q.f.exp));
		s = (a.f.sign == b.f.sign) ? s + t : s - t;
		if (s == 25'd0)
			return r;
		e = int'(p.f.exp);
		if (s[24])
		begin
			s = s >> 1;
			e++;
		end
		while (!s[23])
		begin
			s = s << 1;
			e--;
		end
		r.f.sign = p.f.sign;
		if (e > float_max_exp)
		begin
			r.f.exp = 8'(float_max_exp);
			r.f.man = '1;
		end
		else if (e >= 1)
		begin
			r.f.exp = 8'(e);
			r.f.man = s[22:0];
		end
		return r;
	endfunction

	function automatic float_t model_neuron(input vector_t v);
		float_t t [node_terms];
		int n;
		for (int i = 0; i < node_inputs; i++)
			t[i] = model_mult(v[i], node_weights[i]);
		t[node_inputs] = node_bias;
		// pair term 2k with term 2k+1 and pass an odd last term through
		for (n = node_terms; n > 1; n = (n + 1) / 2)
		begin
			for (int k = 0; k < n / 2; k++)
				t[k] = model_add(t[2*k], t[2*k+1]);
			if (n % 2 == 1)
				t[n/2] = t[n-1];
		end
		if (t[0].f.sign)
			t[0].raw = '0;
		return t[0];
	endfunction

	task automatic drive_sample(input logic valid, input vector_t v, input float_t expected,
		input string name);
		@(posedge clk);
		#2;
		in.valid = valid;
		in.data = v;
		if (valid)
		begin
			exp_val.push_back(expected.raw);
			exp_due.push_back(cycle + node_latency);
			exp_name.push_back(name);
		end
	endtask

	task automatic drop_front();
		void'(exp_val.pop_front());
		void'(exp_due.pop_front());
		void'(exp_name.pop_front());
	endtask

	task automatic apply_reset(input int n);
		@(posedge clk);
		#2;
		reset = 1'b1;
		in.valid = 1'b0;
		// whatever is still in the pipeline is lost
		while (exp_due.size() > 0 && exp_due[$] > cycle)
		begin
			void'(exp_val.pop_back());
			void'(exp_due.pop_back());
			void'(exp_name.pop_back());
		end
		repeat (n) @(posedge clk);
		#2;
		reset = 1'b0;
	endtask

	task automatic report(input bit timed_out);
		int fails;
		fails = errors + uut.u_asserts.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, uut.u_asserts.fail_count);
		if (!timed_out && fails == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
	endtask

	always @(negedge clk)
	begin
		if (out_valid === 1'b1)
		begin
			checks++;
			assert (exp_due.size() > 0 && exp_due[0] == cycle)
			else
			begin
				errors++;
				$display("output %h at cycle %0d arrived with nothing expected", out.raw, cycle);
			end
			if (exp_due.size() > 0 && exp_due[0] == cycle)
			begin
				assert (out.raw == exp_val[0])
				else
				begin
					errors++;
					$display("ERR %s expected %h actual %h", exp_name[0], exp_val[0], out.raw);
				end
				drop_front();
			end
		end
		if (exp_due.size() > 0)
		begin
			assert (exp_due[0] >= cycle)
			else
			begin
				errors++;
				$display("%s output due at cycle %0d never arrived", exp_name[0], exp_due[0]);
				drop_front();
			end
		end
	end

	initial
	begin
		#((total_cycles + 50) * period);
		$display("timeout, the run did not finish within %0d cycles", total_cycles + 50);
		report(1'b1);
		$finish;
	end

	initial
	begin
		vector_t v;
		vector_t clean;
		float_t zero;
		logic [31:0] r;
		zero.raw = '0;
		reset = 1'b1;
		in = '0;
		repeat (reset_cycles) @(posedge clk);
		#2;
		reset = 1'b0;

		for (int i = 0; i < burst_len; i++)
		begin
			v = rand_vector();
			drive_sample(1'b1, v, model_neuron(v), "burst");
		end

		// all products are zero and only the positive bias is left
		v = '0;
		drive_sample(1'b1, v, node_bias, "zero_input");
		v = rand_vector();
		for (int i = 0; i < node_inputs; i++)
		begin
			v[i].f.sign = ~node_weights[i].f.sign;
			v[i].f.exp = 8'd140;
		end
		drive_sample(1'b1, v, zero, "negative_sum");

		for (int i = 0; i < gap_len; i++)
		begin
			v = rand_vector();
			r = $random(seed);
			drive_sample(r[0], v, model_neuron(v), "gaps");
		end

		for (int i = 0; i < denorm_len; i++)
		begin
			v = rand_vector();
			clean = v;
			r = $random(seed);
			for (int j = 0; j < node_inputs; j++)
			begin
				if (r[j])
				begin
					v[j].f.exp = 8'd0;
					clean[j].raw = '0;
				end
			end
			drive_sample(1'b1, v, model_neuron(clean), "denormal");
		end

		for (int i = 0; i < 4; i++)
		begin
			v = rand_vector();
			drive_sample(1'b1, v, model_neuron(v), "in_flight");
		end
		apply_reset(3);
		for (int i = 0; i < 8; i++)
		begin
			v = rand_vector();
			drive_sample(1'b1, v, model_neuron(v), "after_reset");
		end
		drive_sample(1'b0, rand_vector(), zero, "idle");

		while (exp_due.size() > 0)
			@(posedge clk);
		// short window for stray outputs
		repeat (node_latency + 2) @(posedge clk);
		report(1'b0);
		$finish;
	end

endmodule

/* testbench/neuron_node_asserts.sv */
`timescale 1ns/1ps

module neuron_node_asserts (
	input logic clk,
	input logic reset,
	input node_pkg::node_sample_t in,
	input logic out_valid,
	input float_pkg::float_t out
);

	import node_pkg::*;

	// saturating count of cycles since reset was released
	logic [3:0] since_reset;
	int fail_count = 0;

	always_ff @(posedge clk)
	begin
		if (reset)
			since_reset <= '0;
		else if (since_reset != 4'hf)
			since_reset <= since_reset + 4'd1;
	end

	quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
		since_reset < 4'(node_latency) |-> !out_valid)
	else
	begin
		$error("out_valid high before the pipeline could fill after reset");
		fail_count++;
	end

	valid_traced: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> $past(in.valid, node_latency) && since_reset >= 4'(node_latency))
	else
	begin
		$error("out_valid without a matching input strobe");
		fail_count++;
	end

	// rectifier output is never negative
	relu_sign: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> !out.f.sign)
	else
	begin
		$error("valid output with the sign bit set");
		fail_count++;
	end

endmodule

bind neuron_node neuron_node_asserts u_asserts (
	.clk(clk),
	.reset(reset),
	.in(in),
	.out_valid(out_valid),
	.out(out)
);

/* design/neuron_node.sv */
`timescale 1ns/1ps

module neuron_node (
	input logic clk,
	input logic reset,
	input node_pkg::node_sample_t in,
	output logic out_valid,
	output float_pkg::float_t out
);

	import float_pkg::*;
	import node_pkg::*;

	logic mult_valid;
	logic lvl1_valid;
	logic lvl2_valid;
	logic lvl3_valid;
	float_t [node_terms-1:0] mult_terms;
	float_t [5:0] lvl1_terms;
	float_t [2:0] lvl2_terms;
	float_t [1:0] lvl3_terms;

	node_mult_stage u_mult_stage (
		.clk(clk),
		.reset(reset),
		.in(in),
		.valid_out(mult_valid),
		.terms(mult_terms)
	);

	node_tree_level #(.in_terms(node_terms), .apply_relu(1'b0)) u_level1 (
		.clk(clk),
		.reset(reset),
		.valid_in(mult_valid),
		.terms_in(mult_terms),
		.valid_out(lvl1_valid),
		.terms_out(lvl1_terms)
	);

	node_tree_level #(.in_terms(6), .apply_relu(1'b0)) u_level2 (
		.clk(clk),
		.reset(reset),
		.valid_in(lvl1_valid),
		.terms_in(lvl1_terms),
		.valid_out(lvl2_valid),
		.terms_out(lvl2_terms)
	);

	node_tree_level #(.in_terms(3), .apply_relu(1'b0)) u_level3 (
		.clk(clk),
		.reset(reset),
		.valid_in(lvl2_valid),
		.terms_in(lvl2_terms),
		.valid_out(lvl3_valid),
		.terms_out(lvl3_terms)
	);

	// last level carries the rectifier
	node_tree_level #(.in_terms(2), .apply_relu(1'b1)) u_level4 (
		.clk(clk),
		.reset(reset),
		.valid_in(lvl3_valid),
		.terms_in(lvl3_terms),
		.valid_out(out_valid),
		.terms_out(out)
	);

endmodule

/* design/node_tree_level.sv */
`timescale 1ns/1ps

module node_tree_level #(
	parameter int in_terms = 11,
	parameter bit apply_relu = 1'b0
) (
	input logic clk,
	input logic reset,
	input logic valid_in,
	input float_pkg::float_t [in_terms-1:0] terms_in,
	output logic valid_out,
	output float_pkg::float_t [(in_terms+1)/2-1:0] terms_out
);

	import float_pkg::*;

	float_t [(in_terms+1)/2-1:0] level_sum;

	// term 2k plus term 2k+1
	for (genvar k = 0; k < in_terms / 2; k++)
	begin : g_pair
		float_adder u_add (
			.a(terms_in[2*k]),
			.b(terms_in[2*k+1]),
			.sum(level_sum[k])
		);
	end

	// odd term left over goes straight through
	if (in_terms % 2 == 1)
	begin : g_odd
		assign level_sum[in_terms/2] = terms_in[in_terms-1];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			valid_out <= 1'b0;
		else
			valid_out <= valid_in;
	end

	always_ff @(posedge clk)
	begin
		for (int k = 0; k < (in_terms + 1) / 2; k++)
		begin
			// the rectifier turns negative values into +0
			if (apply_relu && level_sum[k].f.sign)
				terms_out[k] <= '0;
			else
				terms_out[k] <= level_sum[k];
		end
	end

endmodule

/* design/node_mult_stage.sv */
`timescale 1ns/1ps

module node_mult_stage (
	input logic clk,
	input logic reset,
	input node_pkg::node_sample_t in,
	output logic valid_out,
	output float_pkg::float_t [node_pkg::node_terms-1:0] terms
);

	import float_pkg::*;
	import node_pkg::*;

	float_t [node_inputs-1:0] products;

	for (genvar i = 0; i < node_inputs; i++)
	begin : g_mult
		float_mult u_mult (
			.x(in.data[i]),
			.y(node_weights[i]),
			.z(products[i])
		);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			valid_out <= 1'b0;
		else
			valid_out <= in.valid;
	end

	// bias rides along as the last term
	always_ff @(posedge clk)
	begin
		terms[node_inputs-1:0] <= products;
		terms[node_inputs] <= node_bias;
	end

endmodule

/* design/float_adder.sv */
`timescale 1ns/1ps

module float_adder (
	input float_pkg::float_t a,
	input float_pkg::float_t b,
	output float_pkg::float_t sum
);

	import float_pkg::*;

	// magnitude is the word without its sign bit
	logic [float_exp_bits+float_man_bits-1:0] a_mag;
	logic [float_exp_bits+float_man_bits-1:0] b_mag;
	logic [float_exp_bits+float_man_bits-1:0] big_mag;
	logic [float_exp_bits+float_man_bits-1:0] small_mag;
	logic swap;
	logic big_sign;
	logic same_sign;
	logic [float_man_bits:0] big_sig;
	logic [float_man_bits:0] small_sig;
	logic [float_man_bits:0] aligned;
	logic [float_man_bits+1:0] raw_sum;
	logic [float_man_bits:0] shifted;
	logic [float_man_bits-1:0] man_n;
	int shift;
	int lz;
	int exp_n;

	always_comb
	begin
		// a zero exponent counts as zero whatever the mantissa holds
		a_mag = (a.f.exp == '0) ? '0 : a.raw[float_exp_bits+float_man_bits-1:0];
		b_mag = (b.f.exp == '0) ? '0 : b.raw[float_exp_bits+float_man_bits-1:0];

		swap = b_mag > a_mag;
		big_mag = swap ? b_mag : a_mag;
		small_mag = swap ? a_mag : b_mag;
		big_sign = swap ? b.f.sign : a.f.sign;
		same_sign = a.f.sign == b.f.sign;

		if (big_mag[float_exp_bits+float_man_bits-1:float_man_bits] == '0)
			big_sig = '0;
		else
			big_sig = {1'b1, big_mag[float_man_bits-1:0]};

		if (small_mag[float_exp_bits+float_man_bits-1:float_man_bits] == '0)
			small_sig = '0;
		else
			small_sig = {1'b1, small_mag[float_man_bits-1:0]};

		shift = int'(big_mag[float_exp_bits+float_man_bits-1:float_man_bits])
			- int'(small_mag[float_exp_bits+float_man_bits-1:float_man_bits]);

		// bits shifted out on alignment are simply lost
		if (shift > float_man_bits)
			aligned = '0;
		else
			aligned = small_sig >> shift;

		if (same_sign)
			raw_sum = {1'b0, big_sig} + {1'b0, aligned};
		else
			raw_sum = {1'b0, big_sig} - {1'b0, aligned};

		// position of the leading one below the carry bit
		lz = 0;
		for (int i = 0; i <= float_man_bits; i++)
		begin
			if (raw_sum[i])
				lz = float_man_bits - i;
		end
		shifted = raw_sum[float_man_bits:0] << lz;

		if (raw_sum[float_man_bits+1])
		begin
			man_n = raw_sum[float_man_bits:1];
			exp_n = int'(big_mag[float_exp_bits+float_man_bits-1:float_man_bits]) + 1;
		end
		else
		begin
			man_n = shifted[float_man_bits-1:0];
			exp_n = int'(big_mag[float_exp_bits+float_man_bits-1:float_man_bits]) - lz;
		end

		if (raw_sum == '0)
		begin
			// exact cancellation is always +0
			sum.f.sign = 1'b0;
			sum.f.exp = '0;
			sum.f.man = '0;
		end
		else if (exp_n < 1)
		begin
			sum.f.sign = big_sign;
			sum.f.exp = '0;
			sum.f.man = '0;
		end
		else if (exp_n > float_max_exp)
		begin
			sum.f.sign = big_sign;
			sum.f.exp = float_exp_bits'(float_max_exp);
			sum.f.man = '1;
		end
		else
		begin
			sum.f.sign = big_sign;
			sum.f.exp = exp_n[float_exp_bits-1:0];
			sum.f.man = man_n;
		end
	end

endmodule

/* design/float_mult.sv */
`timescale 1ns/1ps

module float_mult (
	input float_pkg::float_t x,
	input float_pkg::float_t y,
	output float_pkg::float_t z
);

	import float_pkg::*;

	logic [float_man_bits:0] sig_x;
	logic [float_man_bits:0] sig_y;
	logic [2*float_man_bits+1:0] prod;
	logic [float_man_bits-1:0] man_n;
	logic sign_z;
	int exp_sum;
	int exp_n;

	always_comb
	begin
		sign_z = x.f.sign ^ y.f.sign;
		sig_x = {1'b1, x.f.man};
		sig_y = {1'b1, y.f.man};
		prod = sig_x * sig_y;
		exp_sum = int'(x.f.exp) + int'(y.f.exp) - float_bias_exp;

		// product of two 1.x values lies in [1,4), so one shift at most
		if (prod[2*float_man_bits+1])
		begin
			man_n = prod[2*float_man_bits:float_man_bits+1];
			exp_n = exp_sum + 1;
		end
		else
		begin
			man_n = prod[2*float_man_bits-1:float_man_bits];
			exp_n = exp_sum;
		end

		if (x.f.exp == '0 || y.f.exp == '0 || exp_n < 1)
		begin
			// denormal operands and underflow flush to signed zero
			z.f.sign = sign_z;
			z.f.exp = '0;
			z.f.man = '0;
		end
		else if (exp_n > float_max_exp)
		begin
			z.f.sign = sign_z;
			z.f.exp = float_exp_bits'(float_max_exp);
			z.f.man = '1;
		end
		else
		begin
			z.f.sign = sign_z;
			z.f.exp = exp_n[float_exp_bits-1:0];
			z.f.man = man_n;
		end
	end

endmodule

/* design/node_pkg.sv */
package node_pkg;

	import float_pkg::*;

	localparam int node_inputs = 10;

	// inputs plus the bias term
	localparam int node_terms = node_inputs + 1;

	// multiply stage plus four adder tree levels
	localparam int node_latency = 5;

	// fixed weights with w0 first
	localparam float_t node_weights [node_inputs] = '{
		32'b10111110011101011100001101111011,
		32'b10111110100100010011110100101011,
		32'b10111101110101100011011001000000,
		32'b10111110111000000110100111011011,
		32'b10111110011101000101001010011110,
		32'b00111101101000110000111111100001,
		32'b00111110000100010111011110111110,
		32'b10111101110101101010101110100011,
		32'b10111110011010011010101111001000,
		32'b10111011111110010000001110000000
	};

	localparam float_t node_bias = 32'b00111011000101111100011011100010;

	typedef struct packed
	{
		logic valid;
		float_t [node_inputs-1:0] data;
	} node_sample_t;

endpackage

/* design/float_pkg.sv */
package float_pkg;

	// single precision field widths
	localparam int float_exp_bits = 8;
	localparam int float_man_bits = 23;

	localparam int float_bias_exp = 127;

	// largest exponent of a finite value
	// 255 is kept for inf and nan
	localparam int float_max_exp = 254;

	typedef struct packed
	{
		logic sign;
		logic [float_exp_bits-1:0] exp;
		logic [float_man_bits-1:0] man;
	} float_fields_t;

	// raw view for transport and constants, fields view for arithmetic
	typedef union packed
	{
		logic [float_exp_bits+float_man_bits:0] raw;
		float_fields_t f;
	} float_t;

endpackage
